//--- hw/iiq_pkg.sv
/* sizes, op class enum, micro-op, queue entry and result feedback
   types shared by the integer issue queue. */

package iiq_pkg;

  // --------------------------------------------------
  // sizes
  // --------------------------------------------------
  localparam int num_phys_regs  = 32;
  localparam int phys_reg_width = 5;
  localparam int tag_width      = 6;
  localparam int imm_width      = 32;

  // which issue port an op needs.
  typedef enum logic {
    op_arith = 1'b0,
    op_load  = 1'b1
  } op_class_t;

  // --------------------------------------------------
  // micro-op as seen on dispatch and issue
  // --------------------------------------------------
  typedef struct packed {
    logic                      valid;
    op_class_t                 op_class;
    logic                      rs1_exist;
    logic                      rs2_exist;
    logic                      rd_exist;
    logic [phys_reg_width-1:0] rs1;
    logic [phys_reg_width-1:0] rs2;
    logic [phys_reg_width-1:0] rd;
    logic [imm_width-1:0]      imm;
    logic [tag_width-1:0]      tag;  // active list slot.
  } uop_t;

  // queue entry, micro-op plus source readiness.
  typedef struct packed {
    uop_t uop;
    logic rs1_ready;
    logic rs2_ready;
  } iq_entry_t;

  // one result writeback from an execution unit.
  typedef struct packed {
    logic                      valid;
    logic [phys_reg_width-1:0] rd;
  } feedback_t;

endpackage

//--- hw/iiq_busy_table.sv
/* busy table of physical registers and readiness lookup that turns
   dispatched micro-ops into queue entries. */
`timescale 1ns/1ps

module iiq_busy_table #(
  parameter int dispatch_width = 2,
  parameter int num_feedbacks  = 2
) (
  input  logic                clock,
  input  logic                reset,
  input  logic                flush,
  input  iiq_pkg::uop_t       op_in [dispatch_width],
  input  iiq_pkg::feedback_t  feedback [num_feedbacks],
  output iiq_pkg::iq_entry_t  new_entries [dispatch_width]
);

  // set while a register still waits for its result.
  logic [iiq_pkg::num_phys_regs-1:0] busy;
  logic [iiq_pkg::num_phys_regs-1:0] busy_next;

  // readiness of one source of the op in a given lane.
  function automatic logic src_ready(input logic [iiq_pkg::phys_reg_width-1:0] r,
                                     input int lane);
    logic ready;
    ready = !busy[r];
    // result arriving this cycle.
    for (int f = 0; f < num_feedbacks; f++) begin
      if (feedback[f].valid && feedback[f].rd == r) begin
        ready = 1'b1;
      end
    end
    // an older op of the same group writes it again.
    for (int j = 0; j < dispatch_width; j++) begin
      if (j < lane && op_in[j].valid && op_in[j].rd_exist && op_in[j].rd == r) begin
        ready = 1'b0;
      end
    end
    return ready;
  endfunction

  always_comb begin
    for (int i = 0; i < dispatch_width; i++) begin
      new_entries[i].uop       = op_in[i];
      new_entries[i].rs1_ready = src_ready(op_in[i].rs1, i);
      new_entries[i].rs2_ready = src_ready(op_in[i].rs2, i);
    end
  end

  // --------------------------------------------------
  // table update, new marks win over clears
  // --------------------------------------------------
  always_comb begin
    busy_next = busy;
    for (int f = 0; f < num_feedbacks; f++) begin
      if (feedback[f].valid) begin
        busy_next[feedback[f].rd] = 1'b0;
      end
    end
    for (int i = 0; i < dispatch_width; i++) begin
      if (op_in[i].valid && op_in[i].rd_exist) begin
        busy_next[op_in[i].rd] = 1'b1;
      end
    end
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      busy <= '0;
    end else if (flush) begin
      busy <= '0;
    end else begin
      busy <= busy_next;
    end
  end

endmodule

//--- hw/iiq_entry_store.sv
/* queue entries and count with wakeup, removal of granted entries,
   compaction toward index 0, append of new entries and stall. */
`timescale 1ns/1ps

module iiq_entry_store #(
  parameter int dispatch_width = 2,
  parameter int queue_depth    = 8,
  parameter int num_feedbacks  = 2
) (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   flush,
  input  iiq_pkg::iq_entry_t     new_entries [dispatch_width],
  input  iiq_pkg::feedback_t     feedback [num_feedbacks],
  input  logic [queue_depth-1:0] grant,
  output iiq_pkg::iq_entry_t     entries [queue_depth],
  output logic                   stall
);

  localparam int count_width = $clog2(queue_depth + 1);

  logic [count_width-1:0] count;
  logic [count_width-1:0] count_next;
  iiq_pkg::iq_entry_t     entries_next [queue_depth];
  // a new op found no free slot.
  logic                   overflow;

  // --------------------------------------------------
  // next queue state
  // --------------------------------------------------
  always_comb begin
    int                 pos;
    iiq_pkg::iq_entry_t e;
    pos      = 0;
    overflow = 1'b0;
    for (int i = 0; i < queue_depth; i++) begin
      entries_next[i] = '0;
    end

    // survivors slide down, order kept.
    for (int i = 0; i < queue_depth; i++) begin
      e = entries[i];
      if (e.uop.valid && !grant[i]) begin
        for (int f = 0; f < num_feedbacks; f++) begin
          if (feedback[f].valid) begin
            if (e.uop.rs1_exist && e.uop.rs1 == feedback[f].rd) begin
              e.rs1_ready = 1'b1;
            end
            if (e.uop.rs2_exist && e.uop.rs2 == feedback[f].rd) begin
              e.rs2_ready = 1'b1;
            end
          end
        end
        entries_next[pos] = e;
        pos++;
      end
    end

    // new ops go behind the oldest ones.
    for (int i = 0; i < dispatch_width; i++) begin
      if (new_entries[i].uop.valid) begin
        if (pos < queue_depth) begin
          entries_next[pos] = new_entries[i];
          pos++;
        end else begin
          overflow = 1'b1;
        end
      end
    end
    count_next = count_width'(pos);
  end

  // not enough room for a full dispatch group.
  assign stall = (queue_depth - int'(count)) < dispatch_width;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      entries <= '{default: '0};
      count   <= '0;
    end else if (flush) begin
      entries <= '{default: '0};
      count   <= '0;
    end else begin
      entries <= entries_next;
      count   <= count_next;
    end
  end

  // --------------------------------------------------
  // checks
  // --------------------------------------------------
  // the count never has to grow past the depth.
  a_count_in_range: assert property (
    @(posedge clock) disable iff (reset) !overflow
  );

  // select may only pick occupied slots.
  for (genvar i = 0; i < queue_depth; i++) begin : g_grant_check
    a_grant_valid: assert property (
      @(posedge clock) disable iff (reset) grant[i] |-> entries[i].uop.valid
    );
  end

endmodule

//--- hw/iiq_issue_select.sv
/* oldest-first selection of ready entries for the arithmetic and load
   ports, with registered issue outputs. */
`timescale 1ns/1ps

module iiq_issue_select #(
  parameter int queue_depth     = 8,
  parameter int num_arith_ports = 2
) (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   flush,
  input  logic                   load_stall,
  input  iiq_pkg::iq_entry_t     entries [queue_depth],
  output logic [queue_depth-1:0] grant,
  output iiq_pkg::uop_t          issue_arith [num_arith_ports],
  output iiq_pkg::uop_t          issue_load
);

  iiq_pkg::uop_t arith_next [num_arith_ports];
  iiq_pkg::uop_t load_next;

  // --------------------------------------------------
  // scan from the oldest entry
  // --------------------------------------------------
  always_comb begin
    int   arith_used;
    logic load_used;
    logic ready;
    arith_used = 0;
    load_used  = 1'b0;
    grant      = '0;
    load_next  = '0;
    for (int p = 0; p < num_arith_ports; p++) begin
      arith_next[p] = '0;
    end

    for (int i = 0; i < queue_depth; i++) begin
      ready = entries[i].uop.valid
              && (!entries[i].uop.rs1_exist || entries[i].rs1_ready)
              && (!entries[i].uop.rs2_exist || entries[i].rs2_ready);
      if (ready) begin
        if (entries[i].uop.op_class == iiq_pkg::op_arith) begin
          // first free arithmetic port.
          if (arith_used < num_arith_ports) begin
            arith_next[arith_used] = entries[i].uop;
            arith_used++;
            grant[i] = 1'b1;
          end
        end else if (!load_used && !load_stall) begin
          load_next = entries[i].uop;
          load_used = 1'b1;
          grant[i]  = 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      issue_arith <= '{default: '0};
      issue_load  <= '0;
    end else if (flush) begin
      issue_arith <= '{default: '0};
      issue_load  <= '0;
    end else begin
      issue_arith <= arith_next;
      issue_load  <= load_next;
    end
  end

  // one op never leaves on two arithmetic ports.
  for (genvar i = 0; i < num_arith_ports; i++) begin : g_tag_a
    for (genvar j = i + 1; j < num_arith_ports; j++) begin : g_tag_b
      a_unique_tag: assert property (
        @(posedge clock) disable iff (reset)
        (issue_arith[i].valid && issue_arith[j].valid)
          |-> issue_arith[i].tag != issue_arith[j].tag
      );
    end
  end

endmodule

//--- hw/int_issue_queue.sv
/* integer issue queue top level, busy table, entry store and issue
   select wired together. */
`timescale 1ns/1ps

module int_issue_queue #(
  parameter int dispatch_width  = 2,
  parameter int queue_depth     = 8,
  parameter int num_feedbacks   = 2,
  parameter int num_arith_ports = 2
) (
  input  logic               clock,
  input  logic               reset,
  input  iiq_pkg::uop_t      op_in [dispatch_width],
  input  iiq_pkg::feedback_t feedback [num_feedbacks],
  input  logic               flush,
  input  logic               load_stall,
  output iiq_pkg::uop_t      issue_arith [num_arith_ports],
  output iiq_pkg::uop_t      issue_load,
  output logic               stall
);

  iiq_pkg::iq_entry_t     new_entries [dispatch_width];
  iiq_pkg::iq_entry_t     entries [queue_depth];
  logic [queue_depth-1:0] grant;

  // --------------------------------------------------
  // dispatch side
  // --------------------------------------------------
  iiq_busy_table #(
    .dispatch_width (dispatch_width),
    .num_feedbacks  (num_feedbacks)
  ) u_busy_table (
    .clock       (clock),
    .reset       (reset),
    .flush       (flush),
    .op_in       (op_in),
    .feedback    (feedback),
    .new_entries (new_entries)
  );

  // entries, wakeup and compaction.
  iiq_entry_store #(
    .dispatch_width (dispatch_width),
    .queue_depth    (queue_depth),
    .num_feedbacks  (num_feedbacks)
  ) u_entry_store (
    .clock       (clock),
    .reset       (reset),
    .flush       (flush),
    .new_entries (new_entries),
    .feedback    (feedback),
    .grant       (grant),
    .entries     (entries),
    .stall       (stall)
  );

  // --------------------------------------------------
  // issue side
  // --------------------------------------------------
  iiq_issue_select #(
    .queue_depth     (queue_depth),
    .num_arith_ports (num_arith_ports)
  ) u_issue_select (
    .clock       (clock),
    .reset       (reset),
    .flush       (flush),
    .load_stall  (load_stall),
    .entries     (entries),
    .grant       (grant),
    .issue_arith (issue_arith),
    .issue_load  (issue_load)
  );

endmodule

//--- verification/tb_int_issue_queue.sv
/* testbench for the integer issue queue with clock, reset, directed tests
   for issue timing, wakeup, load back-pressure, full-queue stall and flush. */
`timescale 1ns/1ps

module tb_int_issue_queue;

  localparam int dispatch_width  = 2;
  localparam int num_feedbacks   = 2;
  localparam int num_arith_ports = 2;
  localparam int max_cycles      = 400;

  logic                          clock;
  logic                          reset;
  logic                          flush;
  logic                          load_stall;
  logic                          stall;
  iiq_pkg::uop_t                 op_in [dispatch_width];
  iiq_pkg::feedback_t            feedback [num_feedbacks];
  iiq_pkg::uop_t                 issue_arith [num_arith_ports];
  iiq_pkg::uop_t                 issue_load;
  logic [iiq_pkg::tag_width-1:0] next_tag;
  logic [31:0]                   seed_word;
  int                            cycles = 0;

  int_issue_queue #(
    .dispatch_width  (dispatch_width),
    .queue_depth     (8),
    .num_feedbacks   (num_feedbacks),
    .num_arith_ports (num_arith_ports)
  ) u_int_issue_queue (
    .clock       (clock),
    .reset       (reset),
    .op_in       (op_in),
    .feedback    (feedback),
    .flush       (flush),
    .load_stall  (load_stall),
    .issue_arith (issue_arith),
    .issue_load  (issue_load),
    .stall       (stall)
  );

  always #2 clock = ~clock;

  // run limit.
  always @(posedge clock) begin
    cycles = cycles + 1;
    if (cycles >= max_cycles) begin
      $display("timeout, the tests did not finish within %0d cycles", max_cycles);
      $display("TESTS FAILED");
      $fatal(1, "run stopped by the cycle limit");
    end
  end

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected) begin
      $display("error %s: got 0x%0h, expected 0x%0h", name, actual, expected);
      $display("TESTS FAILED");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  // fresh micro-op with a random immediate and the next tag.
  function automatic iiq_pkg::uop_t new_uop(input iiq_pkg::op_class_t op_class,
                                            input logic rs1_exist,
                                            input logic [iiq_pkg::phys_reg_width-1:0] rs1,
                                            input logic rd_exist,
                                            input logic [iiq_pkg::phys_reg_width-1:0] rd);
    iiq_pkg::uop_t u;
    u           = '0;
    u.valid     = 1'b1;
    u.op_class  = op_class;
    u.rs1_exist = rs1_exist;
    u.rs1       = rs1;
    u.rd_exist  = rd_exist;
    u.rd        = rd;
    u.imm       = $urandom();
    u.tag       = next_tag;
    next_tag    = next_tag + 6'd1;
    return u;
  endfunction

  task automatic clear_inputs();
    for (int i = 0; i < dispatch_width; i++) begin
      op_in[i] = '0;
    end
    for (int f = 0; f < num_feedbacks; f++) begin
      feedback[f] = '0;
    end
  endtask

  task automatic check_no_issue();
    for (int p = 0; p < num_arith_ports; p++) begin
      check_value($sformatf("issue_arith[%0d].valid", p), 64'(issue_arith[p].valid), 64'd0);
    end
    check_value("issue_load.valid", 64'(issue_load.valid), 64'd0);
  endtask

  // --------------------------------------------------
  // directed tests
  // --------------------------------------------------
  task automatic test_reset_state();
    check_no_issue();
    check_value("stall", 64'(stall), 64'd0);
  endtask

  task automatic test_independent_ops();
    iiq_pkg::uop_t a;
    iiq_pkg::uop_t b;
    a = new_uop(iiq_pkg::op_arith, 1'b1, 5'd3, 1'b0, 5'd0);
    b = new_uop(iiq_pkg::op_arith, 1'b1, 5'd4, 1'b0, 5'd0);
    op_in[0] = a;
    op_in[1] = b;
    @(negedge clock);
    clear_inputs();
    check_no_issue();
    @(negedge clock);
    check_value("issue_arith[0]", 64'(issue_arith[0]), 64'(a));
    check_value("issue_arith[1]", 64'(issue_arith[1]), 64'(b));
    @(negedge clock);
    check_no_issue();
  endtask

  task automatic test_wakeup();
    iiq_pkg::uop_t prod;
    iiq_pkg::uop_t cons;
    prod = new_uop(iiq_pkg::op_arith, 1'b0, 5'd0, 1'b1, 5'd5);
    cons = new_uop(iiq_pkg::op_arith, 1'b1, 5'd5, 1'b0, 5'd0);
    op_in[0] = prod;
    @(negedge clock);
    op_in[0] = cons;
    @(negedge clock);
    clear_inputs();
    check_value("issue_arith[0]", 64'(issue_arith[0]), 64'(prod));
    repeat (3) begin
      @(negedge clock);
      check_no_issue();
    end
    // result for register 5.
    feedback[0].valid = 1'b1;
    feedback[0].rd    = 5'd5;
    @(negedge clock);
    clear_inputs();
    check_no_issue();
    @(negedge clock);
    check_value("issue_arith[0]", 64'(issue_arith[0]), 64'(cons));
    check_value("issue_arith[1].valid", 64'(issue_arith[1].valid), 64'd0);
    @(negedge clock);
    check_no_issue();
  endtask

  task automatic test_load_order();
    iiq_pkg::uop_t loads [3];
    for (int i = 0; i < 3; i++) begin
      loads[i] = new_uop(iiq_pkg::op_load, 1'b0, 5'd0, 1'b0, 5'd0);
    end
    load_stall = 1'b1;
    op_in[0]   = loads[0];
    op_in[1]   = loads[1];
    @(negedge clock);
    op_in[0] = loads[2];
    op_in[1] = '0;
    @(negedge clock);
    clear_inputs();
    repeat (3) begin
      @(negedge clock);
      check_no_issue();
    end
    load_stall = 1'b0;
    for (int i = 0; i < 3; i++) begin
      @(negedge clock);
      check_value($sformatf("issue_load (load %0d)", i), 64'(issue_load), 64'(loads[i]));
    end
    @(negedge clock);
    check_no_issue();
  endtask

  // eight ops wait on register 9, which stays busy.
  task automatic test_full_stall();
    op_in[0] = new_uop(iiq_pkg::op_arith, 1'b0, 5'd0, 1'b1, 5'd9);
    @(negedge clock);
    clear_inputs();
    for (int g = 0; g < 4; g++) begin
      check_value("stall", 64'(stall), 64'd0);
      op_in[0] = new_uop(iiq_pkg::op_arith, 1'b1, 5'd9, 1'b0, 5'd0);
      op_in[1] = new_uop(iiq_pkg::op_arith, 1'b1, 5'd9, 1'b0, 5'd0);
      @(negedge clock);
      clear_inputs();
      check_value("stall", 64'(stall), 64'(g == 3));
    end
    @(negedge clock);
    check_no_issue();
    check_value("stall", 64'(stall), 64'd1);
  endtask

  task automatic test_flush();
    iiq_pkg::uop_t fresh;
    flush = 1'b1;
    @(negedge clock);
    flush = 1'b0;
    check_value("stall", 64'(stall), 64'd0);
    check_no_issue();
    // register 9 was busy before the flush.
    fresh    = new_uop(iiq_pkg::op_arith, 1'b1, 5'd9, 1'b0, 5'd0);
    op_in[0] = fresh;
    @(negedge clock);
    clear_inputs();
    check_no_issue();
    @(negedge clock);
    check_value("issue_arith[0]", 64'(issue_arith[0]), 64'(fresh));
    check_value("issue_arith[1].valid", 64'(issue_arith[1].valid), 64'd0);
    check_value("issue_load.valid", 64'(issue_load.valid), 64'd0);
    // a result for register 9 must not wake anything from before the flush.
    feedback[0].valid = 1'b1;
    feedback[0].rd    = 5'd9;
    repeat (4) begin
      @(negedge clock);
      clear_inputs();
      check_no_issue();
    end
  endtask

  initial begin
    clock      = 1'b0;
    reset      = 1'b1;
    flush      = 1'b0;
    load_stall = 1'b0;
    clear_inputs();
    void'($urandom(82328));
    seed_word = $urandom();
    next_tag  = seed_word[5:0];
    repeat (4) @(negedge clock);
    reset = 1'b0;
    test_reset_state();
    test_independent_ops();
    test_wakeup();
    test_load_order();
    test_full_stall();
    test_flush();
    $display("TESTS PASSED");
    $finish;
  end

endmodule

//--- int_issue_queue.f
hw/iiq_pkg.sv
hw/iiq_busy_table.sv
hw/iiq_entry_store.sv
hw/iiq_issue_select.sv
hw/int_issue_queue.sv
verification/tb_int_issue_queue.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the issue queue testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
  -f int_issue_queue.f \
  --top-module tb_int_issue_queue \
  -o tb_int_issue_queue_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_int_issue_queue_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^TESTS PASSED$" "$LOG"; then
  exit 0
else
  echo "pass message not found in $LOG"
  exit 1
fi
